// File: vlog.f
source/credit_link_pkg.sv
source/credit_counter.sv
source/link_arbiter.sv
source/rx_buffer.sv
source/credit_link_top.sv
dv/tb_link_checker.sv
dv/tb_credit_link.sv

// File: dv/tb_credit_link.sv
`timescale 1ns/10ps

module tb_credit_link;

  import credit_link_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CYCLES  = 4;
  localparam int HOLD_CYCLES  = 12;
  localparam int GAP_CYCLES   = 3;
  localparam int MARGIN       = 3;
  localparam int NUM_ROWS     = 8;

  // out_ready modes
  localparam int RDY_HIGH = 0;
  localparam int RDY_HOLD = 1;
  localparam int RDY_RAND = 2;

  typedef struct {
    string name;
    int    flits0;
    int    flits1;
    int    wh;
    int    mode;
    int    wh_after;
    int    max_acc;
  } row_t;

  // ----------------------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------------------

  // wh_after applies once a stalled phase ends
  // max_acc bounds outstanding flits and is the exact accept count of a stall
  row_t rows [NUM_ROWS] = '{
    //  name            flits0 flits1 wh mode      wh_after max_acc
    '{"reset_grant",    3,     3,     0, RDY_HIGH, 0,       4},
    '{"alternate",      8,     8,     0, RDY_HIGH, 0,       4},
    '{"hold_full",      6,     6,     0, RDY_HOLD, 0,       4},
    '{"hold_wh1",       5,     3,     1, RDY_HOLD, 1,       3},
    '{"withhold_all",   2,     2,     4, RDY_HOLD, 0,       0},
    '{"random_wh0",     10,    10,    0, RDY_RAND, 0,       4},
    '{"random_wh2",     7,     9,     2, RDY_RAND, 2,       2},
    '{"single_src",     5,     0,     0, RDY_RAND, 0,       4}
  };

  logic                         clk;
  logic                         rst_n;
  logic [N_SRC-1:0]             src_valid;
  logic [N_SRC-1:0][FLIT_W-1:0] src_data;
  logic [N_SRC-1:0]             src_ready;
  logic [CNT_W-1:0]             withhold;
  logic                         out_valid;
  logic [FLIT_W-1:0]            out_data;
  logic [SRC_W-1:0]             out_src;
  logic                         out_ready;

  // Row control toward the checker
  logic row_start;
  logic hold_check;
  int   limit;
  int   row_pops;
  int   chk_errors;

  int          left [N_SRC];
  int          seq  [N_SRC];
  logic [31:0] lfsr_state;
  int          drain_errors;
  int          tests_failed;
  int          r;

  credit_link_top credit_link_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .src_valid (src_valid),
    .src_data  (src_data),
    .src_ready (src_ready),
    .withhold  (withhold),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_src   (out_src),
    .out_ready (out_ready)
  );

  tb_link_checker checker_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .src_valid  (src_valid),
    .src_data   (src_data),
    .src_ready  (src_ready),
    .withhold   (withhold),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_src    (out_src),
    .out_ready  (out_ready),
    .row_start  (row_start),
    .hold_check (hold_check),
    .limit      (limit),
    .row_pops   (row_pops),
    .err_count  (chk_errors)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // Generous cycle count for one row, used for the drain limit and the watchdog
  function automatic int row_budget(input int idx);
    return (rows[idx].flits0 + rows[idx].flits1) * 6 + HOLD_CYCLES + GAP_CYCLES + 10;
  endfunction

  // Source number in the top bit, running count below
  task automatic drive_sources();
    int i;
    for (i = 0; i < N_SRC; i++) begin
      src_valid[i] = (left[i] > 0);
      src_data[i]  = {i[0], seq[i][FLIT_W-2:0]};
    end
  endtask

  task automatic set_ready(input int mode);
    case (mode)
      RDY_HIGH: out_ready = 1'b1;
      RDY_HOLD: out_ready = 1'b0;
      default: begin
        lfsr_state = lfsr_step(lfsr_state);
        out_ready  = lfsr_state[0];
      end
    endcase
  endtask

  // Note accepts at the rising edge, drive the next values on the falling edge
  task automatic next_cycle(input int mode);
    logic [N_SRC-1:0] taken;
    int               i;
    @(posedge clk);
    taken = src_valid & src_ready;
    @(negedge clk);
    for (i = 0; i < N_SRC; i++) begin
      if (taken[i]) begin
        left[i]--;
        seq[i]++;
      end
    end
    drive_sources();
    set_ready(mode);
  endtask

  task automatic run_row(input int idx);
    int errs_before;
    int total;
    int cycles;
    int phase;
    int errs;
    errs_before = chk_errors + drain_errors;
    total       = rows[idx].flits0 + rows[idx].flits1;
    phase       = rows[idx].mode;
    left[0]     = rows[idx].flits0;
    left[1]     = rows[idx].flits1;
    withhold    = CNT_W'(rows[idx].wh);
    limit       = rows[idx].max_acc;
    row_start   = 1'b1;
    drive_sources();
    set_ready(phase);
    next_cycle(phase);
    row_start = 1'b0;
    if (rows[idx].mode == RDY_HOLD) begin
      // Consumer stalled, accepts stop once the usable credit is spent
      repeat (HOLD_CYCLES) begin
        next_cycle(phase);
      end
      hold_check = 1'b1;
      next_cycle(phase);
      hold_check = 1'b0;
      withhold   = CNT_W'(rows[idx].wh_after);
      limit      = BUF_DEPTH - rows[idx].wh_after;
      phase      = RDY_HIGH;
      out_ready  = 1'b1;
    end
    cycles = 0;
    while (row_pops < total && cycles < row_budget(idx)) begin
      next_cycle(phase);
      cycles++;
    end
    if (row_pops < total) begin
      drain_errors++;
      $display("Test %s stalled with only %0d of %0d flits at the output",
               rows[idx].name, row_pops, total);
      left[0] = 0;
      left[1] = 0;
    end
    drive_sources();
    repeat (GAP_CYCLES) begin
      next_cycle(RDY_HIGH);
    end
    errs = chk_errors + drain_errors - errs_before;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("Test %-13s %s, %0d flits, %0d errors", rows[idx].name,
             (errs == 0) ? "passed" : "failed", total, errs);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    rst_n        = 1'b0;
    src_valid    = '0;
    src_data     = '0;
    withhold     = '0;
    out_ready    = 1'b0;
    row_start    = 1'b0;
    hold_check   = 1'b0;
    limit        = BUF_DEPTH;
    lfsr_state   = 32'he7fc;
    drain_errors = 0;
    tests_failed = 0;
    left[0]      = 0;
    left[1]      = 0;
    seq[0]       = 0;
    seq[1]       = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Quiet sources after reset, nothing may be granted or shown
    repeat (IDLE_CYCLES) begin
      next_cycle(RDY_HIGH);
    end
    for (r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("Summary: %0d tests, %0d failed, %0d checker errors, %0d drain errors",
             NUM_ROWS, tests_failed, chk_errors, drain_errors);
    if (chk_errors + drain_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Run limit from the table lengths
  initial begin : watchdog
    int budget;
    int idx;
    budget = RESET_CYCLES + IDLE_CYCLES;
    for (idx = 0; idx < NUM_ROWS; idx++) begin
      budget += row_budget(idx);
    end
    #(budget * MARGIN * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles before the tests finished", budget * MARGIN);
    $display("Done: errors found");
    $finish;
  end

endmodule : tb_credit_link

// File: dv/tb_link_checker.sv
`timescale 1ns/10ps

// Watches the link ports, predicts grants and credit, and checks every popped flit
module tb_link_checker (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic [credit_link_pkg::N_SRC-1:0]                      src_valid,
  input  logic [credit_link_pkg::N_SRC-1:0][credit_link_pkg::FLIT_W-1:0] src_data,
  input  logic [credit_link_pkg::N_SRC-1:0]                      src_ready,
  input  logic [credit_link_pkg::CNT_W-1:0]                      withhold,
  input  logic                                                   out_valid,
  input  logic [credit_link_pkg::FLIT_W-1:0]                     out_data,
  input  logic [credit_link_pkg::SRC_W-1:0]                      out_src,
  input  logic                                                   out_ready,
  // Row control from the testbench top
  input  logic                                                   row_start,
  input  logic                                                   hold_check,
  input  int                                                     limit,
  output int                                                     row_pops,
  output int                                                     err_count
);

  import credit_link_pkg::*;

  // Accepted flits per source in arrival order
  logic [FLIT_W-1:0] sent_q [N_SRC][$];

  int               row_accepts;
  int               outstanding;
  int               credit;
  int               avail;
  int               last_src;
  int               exp_idx;
  int               idx;
  logic             pop_prev;
  logic [N_SRC-1:0] exp_ready;
  logic [FLIT_W-1:0] head;

  task automatic report_mismatch(input string sig, input int exp, input int got);
    err_count++;
    $display("Error at %0d ns: %s expected %0h, got %0h", $time, sig, exp, got);
  endtask

  task automatic report_fault(input string what);
    err_count++;
    $display("At %0d ns: %s", $time, what);
  endtask

  initial begin
    err_count = 0;
    row_pops  = 0;
  end

  // ----------------------------------------------------------------------
  // Per-edge checks on values from before the DUT registers update
  // ----------------------------------------------------------------------

  always @(posedge clk) begin
    if (!rst_n) begin
      sent_q[0].delete();
      sent_q[1].delete();
      // Priority starts at source 0 as if source 1 had won last
      last_src    = 1;
      pop_prev    = 1'b0;
      row_accepts = 0;
      row_pops    = 0;
    end else begin
      if (row_start) begin
        row_accepts = 0;
        row_pops    = 0;
      end
      outstanding = sent_q[0].size() + sent_q[1].size();

      // Held flits show at the output one cycle after they land
      if (out_valid !== (outstanding != 0)) begin
        report_mismatch("out_valid", int'(outstanding != 0), int'(out_valid));
      end

      // Counter view where a credit popped last edge is still on its way back
      credit = BUF_DEPTH - outstanding - (pop_prev ? 1 : 0);
      avail  = (credit > int'(withhold)) ? credit - int'(withhold) : 0;

      // Round robin gives the loser of the last grant first turn
      if (src_valid == 2'b11) begin
        exp_idx = (last_src == 0) ? 1 : 0;
      end else begin
        exp_idx = src_valid[0] ? 0 : 1;
      end
      exp_ready = '0;
      if (avail > 0 && src_valid != '0) begin
        exp_ready[exp_idx] = 1'b1;
      end
      if (src_ready !== exp_ready) begin
        report_mismatch("src_ready", int'(exp_ready), int'(src_ready));
      end

      // End of a stalled phase
      if (hold_check && row_accepts != limit) begin
        report_mismatch("accepts", limit, row_accepts);
      end

      // Pop side
      pop_prev = out_valid && out_ready;
      if (pop_prev) begin
        if (sent_q[out_src].size() == 0) begin
          report_fault($sformatf("flit popped for source %0d with none outstanding", out_src));
        end else begin
          head = sent_q[out_src].pop_front();
          if (out_data !== head) begin
            report_mismatch("out_data", int'(head), int'(out_data));
          end
        end
        row_pops++;
      end

      // Accept side
      for (idx = 0; idx < N_SRC; idx++) begin
        if (src_valid[idx] && src_ready[idx]) begin
          sent_q[idx].push_back(src_data[idx]);
          row_accepts++;
          last_src = idx;
        end
      end

      outstanding = sent_q[0].size() + sent_q[1].size();
      if (outstanding > limit) begin
        report_fault($sformatf("%0d flits outstanding, above the limit of %0d",
                               outstanding, limit));
      end
    end
  end

endmodule : tb_link_checker

// File: source/credit_link_top.sv
`timescale 1ns/10ps

// Two peer sources sharing one credit-controlled link into a receive FIFO
module credit_link_top (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  // Source side
  input  logic [credit_link_pkg::N_SRC-1:0]                      src_valid,
  input  logic [credit_link_pkg::N_SRC-1:0][credit_link_pkg::FLIT_W-1:0] src_data,
  output logic [credit_link_pkg::N_SRC-1:0]                      src_ready,
  // Credits kept out of use
  input  logic [credit_link_pkg::CNT_W-1:0]                      withhold,
  // Consumer side
  output logic                                                   out_valid,
  output logic [credit_link_pkg::FLIT_W-1:0]                     out_data,
  output logic [credit_link_pkg::SRC_W-1:0]                      out_src,
  input  logic                                                   out_ready
);

  import credit_link_pkg::*;

  // ----------------------------------------------------------------------
  // Internal link and credit wires
  // ----------------------------------------------------------------------

  logic              link_valid;
  logic [FLIT_W-1:0] link_data;
  logic [SRC_W-1:0]  link_src;

  // Credit spent on every link transfer
  logic              credit_take;
  logic              credit_return;
  logic [CNT_W-1:0]  credit_available;

  assign credit_take = link_valid;

  // ----------------------------------------------------------------------
  // Arbiter
  // ----------------------------------------------------------------------

  link_arbiter link_arbiter_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .src_valid        (src_valid),
    .src_data         (src_data),
    .src_ready        (src_ready),
    .credit_available (credit_available),
    .link_valid       (link_valid),
    .link_data        (link_data),
    .link_src         (link_src)
  );

  // ----------------------------------------------------------------------
  // Sender credit pool
  // ----------------------------------------------------------------------

  // Pool sized to the receive FIFO
  credit_counter #(
    .MaxValue (BUF_DEPTH)
  ) credit_counter_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .incr_valid (credit_return),
    .decr_valid (credit_take),
    .withhold   (withhold),
    .value      (),
    .available  (credit_available)
  );

  // ----------------------------------------------------------------------
  // Receive FIFO
  // ----------------------------------------------------------------------

  rx_buffer rx_buffer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .link_valid    (link_valid),
    .link_data     (link_data),
    .link_src      (link_src),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .out_src       (out_src),
    .out_ready     (out_ready),
    .credit_return (credit_return)
  );

endmodule : credit_link_top

// File: source/rx_buffer.sv
`timescale 1ns/10ps

// Receive side FIFO
// Holds flits with their source tag until the consumer pops them
// Each pop sends one credit back to the sender
module rx_buffer (
  input  logic                               clk,
  input  logic                               rst_n,
  // Link from the arbiter
  input  logic                               link_valid,
  input  logic [credit_link_pkg::FLIT_W-1:0] link_data,
  input  logic [credit_link_pkg::SRC_W-1:0]  link_src,
  // Consumer side valid/ready
  output logic                               out_valid,
  output logic [credit_link_pkg::FLIT_W-1:0] out_data,
  output logic [credit_link_pkg::SRC_W-1:0]  out_src,
  input  logic                               out_ready,
  // One pulse per popped flit
  output logic                               credit_return
);

  import credit_link_pkg::*;

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------

  // Payload entries
  logic [FLIT_W-1:0] data_mem [BUF_DEPTH];

  // Source tag entries
  logic [SRC_W-1:0]  src_mem  [BUF_DEPTH];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;

  // Entries currently held
  logic [CNT_W-1:0]  count;

  logic              push;
  logic              pop;

  // Never refused
  // The credit loop keeps the FIFO from filling past its depth
  assign push = link_valid;
  assign pop  = out_valid && out_ready;

  // Pointer advance with wrap at the last entry
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  // Write port
  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_ptr] <= link_data;
      src_mem[wr_ptr]  <= link_src;
    end
  end

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Simultaneous push and pop leave the count alone
      if (push && !pop) begin
        count <= count + CNT_W'(1);
      end else if (pop && !push) begin
        count <= count - CNT_W'(1);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Output
  // ----------------------------------------------------------------------

  // Head entry shows up the cycle after it is written
  assign out_valid = (count != '0);
  assign out_data  = data_mem[rd_ptr];
  assign out_src   = src_mem[rd_ptr];

  // Credit goes back one cycle after the pop
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_return <= 1'b0;
    end else begin
      credit_return <= pop;
    end
  end

endmodule : rx_buffer

// File: source/link_arbiter.sv
`timescale 1ns/10ps

// Round-robin owner of the shared link
// Grants at most one source per cycle and only while credit remains
module link_arbiter (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  // Source side valid/ready
  input  logic [credit_link_pkg::N_SRC-1:0]                      src_valid,
  input  logic [credit_link_pkg::N_SRC-1:0][credit_link_pkg::FLIT_W-1:0] src_data,
  output logic [credit_link_pkg::N_SRC-1:0]                      src_ready,
  // Credit left in the sender pool
  input  logic [credit_link_pkg::CNT_W-1:0]                      credit_available,
  // Link toward the receive buffer
  output logic                                                   link_valid,
  output logic [credit_link_pkg::FLIT_W-1:0]                     link_data,
  output logic [credit_link_pkg::SRC_W-1:0]                      link_src
);

  import credit_link_pkg::*;

  // ----------------------------------------------------------------------
  // Priority state
  // ----------------------------------------------------------------------

  prio_e prio;

  // Index of the favoured source and of the other one
  logic [SRC_W-1:0] prio_idx;
  logic [SRC_W-1:0] other_idx;

  assign prio_idx  = SRC_W'(prio);
  assign other_idx = ~prio_idx;

  // ----------------------------------------------------------------------
  // Grant
  // ----------------------------------------------------------------------

  logic             has_credit;
  logic             any_req;
  logic [SRC_W-1:0] grant_idx;
  logic             grant;

  // One credit buys one flit
  assign has_credit = (credit_available != '0);

  assign any_req = src_valid[prio_idx] || src_valid[other_idx];

  // Favoured source first, the other only if the favoured one is idle
  assign grant_idx = src_valid[prio_idx] ? prio_idx : other_idx;

  // Grant needs both a request and a credit
  assign grant = has_credit && any_req;

  // One-hot ready back to the sources
  always_comb begin
    src_ready = '0;
    if (grant) begin
      src_ready[grant_idx] = 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Link drive
  // ----------------------------------------------------------------------

  // Valid only on a grant
  // Data and tag follow the selected source in every cycle
  assign link_valid = grant;
  assign link_src   = grant_idx;
  assign link_data  = src_data[grant_idx];

  // ----------------------------------------------------------------------
  // Priority update
  // ----------------------------------------------------------------------

  // Priority passes to the source that lost, so steady requesters alternate
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prio <= PRIO_SRC0;
    end else if (grant) begin
      if (grant_idx == SRC_W'(PRIO_SRC0)) begin
        prio <= PRIO_SRC1;
      end else begin
        prio <= PRIO_SRC0;
      end
    end
  end

endmodule : link_arbiter

// File: source/credit_counter.sv
`timescale 1ns/10ps

// Sender-side credit pool
// One credit per flit sent, one credit back per buffer pop
module credit_counter #(
  // Size of the credit pool, the count never rises above it
  parameter int MaxValue = credit_link_pkg::BUF_DEPTH
) (
  input  logic                            clk,
  input  logic                            rst_n,
  // Credit coming back from the receiver
  input  logic                            incr_valid,
  // Credit spent on a flit
  input  logic                            decr_valid,
  // Credits held out of circulation
  input  logic [credit_link_pkg::CNT_W-1:0] withhold,
  // Registered credit count
  output logic [credit_link_pkg::CNT_W-1:0] value,
  // Credits the sender may use this cycle
  output logic [credit_link_pkg::CNT_W-1:0] available
);

  import credit_link_pkg::*;

  // ----------------------------------------------------------------------
  // Next count
  // ----------------------------------------------------------------------

  logic             incr_ok;
  logic [CNT_W-1:0] value_plus;
  logic [CNT_W-1:0] value_next;

  // Pool ceiling
  // A return is dropped only if the pool is already full and no credit
  // leaves in the same cycle
  assign incr_ok = incr_valid && ((value < CNT_W'(MaxValue)) || decr_valid);

  // Increment and decrement may both fire
  // The count then moves by their difference, zero here
  assign value_plus = incr_ok ? value + CNT_W'(1) : value;
  assign value_next = decr_valid ? value_plus - CNT_W'(1) : value_plus;

  // ----------------------------------------------------------------------
  // Credit register
  // ----------------------------------------------------------------------

  // Starts full since the buffer is empty after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value <= CNT_W'(BUF_DEPTH);
    end else if (incr_ok || decr_valid) begin
      value <= value_next;
    end
  end

  // ----------------------------------------------------------------------
  // Withhold
  // ----------------------------------------------------------------------

  // Taken from the registered count
  // The decrement comes from the grant, which itself reads this output
  // Clipped at zero once withhold reaches the count
  always_comb begin
    if (value > withhold) begin
      available = value - withhold;
    end else begin
      available = '0;
    end
  end

endmodule : credit_counter

// File: source/credit_link_pkg.sv
package credit_link_pkg;

  // ----------------------------------------------------------------------
  // Link dimensions
  // ----------------------------------------------------------------------

  // Peer sources sharing the link
  localparam int N_SRC = 2;

  // Source tag carried with every flit
  localparam int SRC_W = 1;

  // Flit payload
  localparam int FLIT_W = 8;

  // ----------------------------------------------------------------------
  // Buffer and credit sizing
  // ----------------------------------------------------------------------

  // Receive buffer entries, also the credit count after reset
  localparam int BUF_DEPTH = 4;

  // Credit counter and occupancy width, holds 0 up to BUF_DEPTH
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  // Read and write pointer width inside the receive buffer
  localparam int PTR_W = $clog2(BUF_DEPTH);

  // ----------------------------------------------------------------------
  // Arbiter state
  // ----------------------------------------------------------------------

  // Source that wins when both request in the same cycle
  typedef enum logic [0:0] {
    PRIO_SRC0 = 1'b0,
    PRIO_SRC1 = 1'b1
  } prio_e;

endpackage : credit_link_pkg
